//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall
TOP        = exe_stage_tb
RTL_TOP    = exe_stage
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log

SOURCES = $(wildcard source/*.sv) $(wildcard verification/*.sv) \
          $(wildcard verification/*.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+verification
source/exe_op_pkg.sv
source/exe_bus_pkg.sv
source/exe_decode.sv
source/exe_divider.sv
source/exe_execute.sv
source/exe_result.sv
source/exe_stage.sv
verification/exe_stage_tb.sv

//--- source/exe_bus_pkg.sv
package exe_bus_pkg;
    import exe_op_pkg::*;

    typedef logic [31:0] word_t;
    // hi in the upper half
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;

    typedef struct packed {
        aluop_t    aluop;
        word_t     src1;
        word_t     src2;
        reg_addr_t wa;
        logic      wreg;
        logic      whilo;
        word_t     ret_addr;
    } exe_issue_t;

    typedef struct packed {
        logic   whilo;
        dword_t hilo;
    } hilo_fwd_t;

    typedef struct packed {
        word_t  logic_res;
        word_t  arith_res;
        word_t  shift_res;
        dword_t product;
        dword_t div_res;
        logic   ovf;
    } unit_res_t;

    typedef struct packed {
        reg_addr_t wa;
        logic      wreg;
        word_t     wd;
        logic      whilo;
        dword_t    hilo;
        logic      ovf;
    } exe_result_t;

endpackage

//--- source/exe_decode.sv
`timescale 1ns/1ps

module exe_decode
    import exe_op_pkg::*;
(
    input  aluop_t    aluop_i,
    output exe_ctrl_t ctrl_o
);

    always_comb begin
        ctrl_o = '0;
        ctrl_o.alu_class = CLASS_NONE;
        ctrl_o.hilo_src  = HILO_NONE;
        case (aluop_i)
            OP_AND, OP_ANDI: begin
                ctrl_o.alu_class = CLASS_LOGIC;
                ctrl_o.logic_op  = LOG_AND;
            end
            OP_OR, OP_ORI: begin
                ctrl_o.alu_class = CLASS_LOGIC;
                ctrl_o.logic_op  = LOG_OR;
            end
            OP_XOR, OP_XORI: begin
                ctrl_o.alu_class = CLASS_LOGIC;
                ctrl_o.logic_op  = LOG_XOR;
            end
            OP_NOR: begin
                ctrl_o.alu_class = CLASS_LOGIC;
                ctrl_o.logic_op  = LOG_NOR;
            end
            OP_LUI: begin
                ctrl_o.alu_class = CLASS_LOGIC;
                ctrl_o.logic_op  = LOG_LUI;
            end
            OP_ADD, OP_ADDI: begin
                ctrl_o.alu_class = CLASS_ARITH;
                ctrl_o.ovf_chk   = 1'b1;
            end
            OP_ADDU, OP_ADDIU, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW: begin
                ctrl_o.alu_class = CLASS_ARITH;
            end
            OP_SUB: begin
                ctrl_o.alu_class = CLASS_ARITH;
                ctrl_o.sub       = 1'b1;
                ctrl_o.ovf_chk   = 1'b1;
            end
            OP_SUBU: begin
                ctrl_o.alu_class = CLASS_ARITH;
                ctrl_o.sub       = 1'b1;
            end
            OP_SLT, OP_SLTI: begin
                ctrl_o.alu_class  = CLASS_ARITH;
                ctrl_o.cmp        = 1'b1;
                ctrl_o.cmp_signed = 1'b1;
            end
            OP_SLTU, OP_SLTIU: begin
                ctrl_o.alu_class = CLASS_ARITH;
                ctrl_o.cmp       = 1'b1;
            end
            OP_SLL, OP_SLLV: begin
                ctrl_o.alu_class = CLASS_SHIFT;
                ctrl_o.shift_op  = SHIFT_LL;
            end
            OP_SRL, OP_SRLV: begin
                ctrl_o.alu_class = CLASS_SHIFT;
                ctrl_o.shift_op  = SHIFT_RL;
            end
            OP_SRA, OP_SRAV: begin
                ctrl_o.alu_class = CLASS_SHIFT;
                ctrl_o.shift_op  = SHIFT_RA;
            end
            OP_MULT, OP_MULTU: begin
                ctrl_o.md_signed = (aluop_i == OP_MULT);
                ctrl_o.hilo_src  = HILO_MULT;
            end
            OP_DIV, OP_DIVU: begin
                ctrl_o.md_signed = (aluop_i == OP_DIV);
                ctrl_o.div       = 1'b1;
                ctrl_o.hilo_src  = HILO_DIV;
            end
            OP_MFHI: begin
                ctrl_o.alu_class = CLASS_MOVE;
                ctrl_o.move_src  = MOVE_HI;
            end
            OP_MFLO: begin
                ctrl_o.alu_class = CLASS_MOVE;
                ctrl_o.move_src  = MOVE_LO;
            end
            OP_MTHI: ctrl_o.hilo_src  = HILO_MTHI;
            OP_MTLO: ctrl_o.hilo_src  = HILO_MTLO;
            OP_JAL:  ctrl_o.alu_class = CLASS_JUMP;
            default: ;
        endcase
    end

endmodule

//--- source/exe_divider.sv
`timescale 1ns/1ps

module exe_divider
    import exe_bus_pkg::*;
(
    input  logic   cpu_clk_50M,
    input  logic   reset_i,
    input  logic   start_i,
    input  logic   signed_i,
    input  word_t  dividend_i,
    input  word_t  divisor_i,
    output logic   ready_o,
    output dword_t result_o
);

    typedef enum logic [1:0] {DIV_IDLE, DIV_ZERO, DIV_RUN, DIV_DONE} div_state_t;

    div_state_t state;
    logic [4:0] cnt;
    word_t      rem_q;
    word_t      quo_q;
    word_t      dvs_q;
    logic       neg_quo;
    logic       neg_rem;

    logic [33:0] partial;
    logic [34:0] diff1;
    logic [34:0] diff2;
    logic [34:0] diff3;
    word_t       rem_next;
    logic [1:0]  qbits;

    // one radix-4 step, largest multiple of the divisor that fits
    always_comb begin
        partial = {rem_q, quo_q[31:30]};
        diff1   = {1'b0, partial} - {3'b000, dvs_q};
        diff2   = {1'b0, partial} - {2'b00, dvs_q, 1'b0};
        diff3   = {1'b0, partial} - ({3'b000, dvs_q} + {2'b00, dvs_q, 1'b0});
        if (!diff3[34]) begin
            rem_next = diff3[31:0];
            qbits    = 2'd3;
        end else if (!diff2[34]) begin
            rem_next = diff2[31:0];
            qbits    = 2'd2;
        end else if (!diff1[34]) begin
            rem_next = diff1[31:0];
            qbits    = 2'd1;
        end else begin
            rem_next = partial[31:0];
            qbits    = 2'd0;
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (reset_i) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start_i) begin
                        state <= (divisor_i == '0) ? DIV_ZERO : DIV_RUN;
                        cnt   <= '0;
                    end
                end
                DIV_ZERO: state <= DIV_DONE;
                DIV_RUN: begin
                    // 16 steps, then one cycle of sign fix-up
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd16) begin
                        state <= DIV_DONE;
                    end
                end
                // ready is up here, the issue moves on after this cycle
                DIV_DONE: state <= DIV_IDLE;
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        case (state)
            DIV_IDLE: begin
                rem_q   <= '0;
                quo_q   <= (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
                dvs_q   <= (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;
                neg_quo <= signed_i && (dividend_i[31] ^ divisor_i[31]);
                neg_rem <= signed_i && dividend_i[31];
            end
            DIV_ZERO: begin
                rem_q <= '0;
                quo_q <= '0;
            end
            DIV_RUN: begin
                if (cnt != 5'd16) begin
                    rem_q <= rem_next;
                    quo_q <= {quo_q[29:0], qbits};
                end else begin
                    // remainder follows the dividend sign
                    quo_q <= neg_quo ? -quo_q : quo_q;
                    rem_q <= neg_rem ? -rem_q : rem_q;
                end
            end
            default: ;
        endcase
    end

    assign ready_o  = (state == DIV_DONE);
    assign result_o = {rem_q, quo_q};

endmodule

//--- source/exe_execute.sv
`timescale 1ns/1ps

module exe_execute
    import exe_op_pkg::*;
    import exe_bus_pkg::*;
(
    input  logic      cpu_clk_50M,
    input  logic      reset_i,
    input  exe_ctrl_t ctrl_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    output unit_res_t units_o,
    output logic      div_busy_o
);

    word_t               operand_b;
    word_t               sum;
    logic                less;
    logic [4:0]          shamt;
    logic signed [63:0]  prod_s;
    dword_t              prod_u;
    logic                div_start;
    logic                div_ready;
    dword_t              div_res;

    always_comb begin
        case (ctrl_i.logic_op)
            LOG_AND: units_o.logic_res = src1_i & src2_i;
            LOG_OR:  units_o.logic_res = src1_i | src2_i;
            LOG_XOR: units_o.logic_res = src1_i ^ src2_i;
            LOG_NOR: units_o.logic_res = ~(src1_i | src2_i);
            // immediate arrives already shifted into the upper half
            LOG_LUI: units_o.logic_res = src2_i;
            default: units_o.logic_res = '0;
        endcase
    end

    // subtract through the inverted operand and carry in
    assign operand_b = ctrl_i.sub ? ~src2_i : src2_i;
    assign sum       = src1_i + operand_b + word_t'(ctrl_i.sub);
    assign less      = ctrl_i.cmp_signed ? ($signed(src1_i) < $signed(src2_i))
                                         : (src1_i < src2_i);

    assign units_o.arith_res = ctrl_i.cmp ? word_t'(less) : sum;

    // operands of equal sign giving a result of the other sign
    assign units_o.ovf = ctrl_i.ovf_chk && (src1_i[31] == operand_b[31])
                         && (sum[31] != src1_i[31]);

    assign shamt = src1_i[4:0];

    always_comb begin
        case (ctrl_i.shift_op)
            SHIFT_LL: units_o.shift_res = src2_i << shamt;
            SHIFT_RL: units_o.shift_res = src2_i >> shamt;
            SHIFT_RA: units_o.shift_res = word_t'($signed(src2_i) >>> shamt);
            default:  units_o.shift_res = '0;
        endcase
    end

    assign prod_s = $signed(src1_i) * $signed(src2_i);
    assign prod_u = {32'b0, src1_i} * {32'b0, src2_i};

    assign units_o.product = ctrl_i.md_signed ? dword_t'(prod_s) : prod_u;

    assign div_start  = ctrl_i.div && !div_ready;
    assign div_busy_o = div_start;

    exe_divider u_divider (
        .cpu_clk_50M (cpu_clk_50M),
        .reset_i     (reset_i),
        .start_i     (div_start),
        .signed_i    (ctrl_i.md_signed),
        .dividend_i  (src1_i),
        .divisor_i   (src2_i),
        .ready_o     (div_ready),
        .result_o    (div_res)
    );

    assign units_o.div_res = div_res;

endmodule

//--- source/exe_op_pkg.sv
package exe_op_pkg;

    typedef logic [7:0] aluop_t;

    // logic
    localparam aluop_t OP_AND   = 8'h1c;
    localparam aluop_t OP_ANDI  = 8'h1e;
    localparam aluop_t OP_OR    = 8'h1f;
    localparam aluop_t OP_ORI   = 8'h1d;
    localparam aluop_t OP_XOR   = 8'h20;
    localparam aluop_t OP_XORI  = 8'h21;
    localparam aluop_t OP_NOR   = 8'h22;
    localparam aluop_t OP_LUI   = 8'h05;

    // arithmetic and compare
    localparam aluop_t OP_ADD   = 8'h18;
    localparam aluop_t OP_ADDI  = 8'h1a;
    localparam aluop_t OP_ADDU  = 8'h23;
    localparam aluop_t OP_ADDIU = 8'h19;
    localparam aluop_t OP_SUB   = 8'h24;
    localparam aluop_t OP_SUBU  = 8'h1b;
    localparam aluop_t OP_SLT   = 8'h26;
    localparam aluop_t OP_SLTI  = 8'h28;
    localparam aluop_t OP_SLTU  = 8'h29;
    localparam aluop_t OP_SLTIU = 8'h27;

    // loads and stores only need the address add here
    localparam aluop_t OP_LB    = 8'h90;
    localparam aluop_t OP_LBU   = 8'h91;
    localparam aluop_t OP_LH    = 8'h93;
    localparam aluop_t OP_LHU   = 8'h94;
    localparam aluop_t OP_LW    = 8'h92;
    localparam aluop_t OP_SB    = 8'h98;
    localparam aluop_t OP_SH    = 8'h99;
    localparam aluop_t OP_SW    = 8'h9a;

    // shifts
    localparam aluop_t OP_SLL   = 8'h11;
    localparam aluop_t OP_SLLV  = 8'h12;
    localparam aluop_t OP_SRL   = 8'h13;
    localparam aluop_t OP_SRLV  = 8'h15;
    localparam aluop_t OP_SRA   = 8'h16;
    localparam aluop_t OP_SRAV  = 8'h17;

    // hi/lo and jump
    localparam aluop_t OP_MULT  = 8'h14;
    localparam aluop_t OP_MULTU = 8'h25;
    localparam aluop_t OP_DIV   = 8'h2a;
    localparam aluop_t OP_DIVU  = 8'h2b;
    localparam aluop_t OP_MFHI  = 8'h0c;
    localparam aluop_t OP_MFLO  = 8'h0d;
    localparam aluop_t OP_MTHI  = 8'h0e;
    localparam aluop_t OP_MTLO  = 8'h0f;
    localparam aluop_t OP_JAL   = 8'h2c;

    typedef enum logic [2:0] {
        CLASS_NONE, CLASS_LOGIC, CLASS_ARITH, CLASS_SHIFT, CLASS_MOVE, CLASS_JUMP
    } alu_class_t;

    typedef enum logic [2:0] {
        HILO_NONE, HILO_MULT, HILO_DIV, HILO_MTHI, HILO_MTLO
    } hilo_src_t;

    typedef enum logic [2:0] {LOG_AND, LOG_OR, LOG_XOR, LOG_NOR, LOG_LUI} logic_op_t;
    typedef enum logic [1:0] {SHIFT_LL, SHIFT_RL, SHIFT_RA} shift_op_t;
    typedef enum logic {MOVE_HI, MOVE_LO} move_src_t;

    typedef struct packed {
        alu_class_t alu_class;
        logic_op_t  logic_op;
        shift_op_t  shift_op;
        logic       sub;
        logic       cmp;
        logic       cmp_signed;
        logic       md_signed;
        logic       div;
        logic       ovf_chk;
        move_src_t  move_src;
        hilo_src_t  hilo_src;
    } exe_ctrl_t;

endpackage

//--- source/exe_result.sv
`timescale 1ns/1ps

module exe_result
    import exe_op_pkg::*;
    import exe_bus_pkg::*;
(
    input  logic        reset_i,
    input  exe_issue_t  issue_i,
    input  exe_ctrl_t   ctrl_i,
    input  unit_res_t   units_i,
    input  logic        div_busy_i,
    input  word_t       hi_i,
    input  word_t       lo_i,
    input  hilo_fwd_t   fwd_mem_i,
    input  hilo_fwd_t   fwd_wb_i,
    output exe_result_t result_o,
    output logic        stall_o
);

    dword_t hilo_cur;
    word_t  hi_cur;
    word_t  lo_cur;
    word_t  move_res;

    // newest value wins: memory, then writeback, then register file
    assign hilo_cur = fwd_mem_i.whilo ? fwd_mem_i.hilo :
                      fwd_wb_i.whilo  ? fwd_wb_i.hilo  : {hi_i, lo_i};
    assign hi_cur   = hilo_cur[63:32];
    assign lo_cur   = hilo_cur[31:0];

    assign move_res = (ctrl_i.move_src == MOVE_HI) ? hi_cur : lo_cur;

    always_comb begin
        case (ctrl_i.alu_class)
            CLASS_LOGIC: result_o.wd = units_i.logic_res;
            CLASS_ARITH: result_o.wd = units_i.arith_res;
            CLASS_SHIFT: result_o.wd = units_i.shift_res;
            CLASS_MOVE:  result_o.wd = move_res;
            CLASS_JUMP:  result_o.wd = issue_i.ret_addr;
            default:     result_o.wd = '0;
        endcase
    end

    always_comb begin
        case (ctrl_i.hilo_src)
            HILO_MULT: result_o.hilo = units_i.product;
            HILO_DIV:  result_o.hilo = units_i.div_res;
            HILO_MTHI: result_o.hilo = {issue_i.src1, lo_cur};
            HILO_MTLO: result_o.hilo = {hi_cur, issue_i.src1};
            default:   result_o.hilo = '0;
        endcase
    end

    assign result_o.wa    = issue_i.wa;
    assign result_o.wreg  = !reset_i && issue_i.wreg;
    assign result_o.whilo = !reset_i && issue_i.whilo;
    assign result_o.ovf   = !reset_i && units_i.ovf;

    assign stall_o = !reset_i && div_busy_i;

endmodule

//--- source/exe_stage.sv
`timescale 1ns/1ps

module exe_stage
    import exe_op_pkg::*;
    import exe_bus_pkg::*;
(
    input  logic        cpu_clk_50M,
    input  logic        reset_i,
    input  exe_issue_t  issue_i,
    input  word_t       hi_i,
    input  word_t       lo_i,
    input  hilo_fwd_t   fwd_mem_i,
    input  hilo_fwd_t   fwd_wb_i,
    output exe_result_t result_o,
    output logic        stall_o
);

    exe_ctrl_t ctrl;
    unit_res_t units;
    logic      div_busy;

    exe_decode u_decode (
        .aluop_i (issue_i.aluop),
        .ctrl_o  (ctrl)
    );

    exe_execute u_execute (
        .cpu_clk_50M (cpu_clk_50M),
        .reset_i     (reset_i),
        .ctrl_i      (ctrl),
        .src1_i      (issue_i.src1),
        .src2_i      (issue_i.src2),
        .units_o     (units),
        .div_busy_o  (div_busy)
    );

    exe_result u_result (
        .reset_i    (reset_i),
        .issue_i    (issue_i),
        .ctrl_i     (ctrl),
        .units_i    (units),
        .div_busy_i (div_busy),
        .hi_i       (hi_i),
        .lo_i       (lo_i),
        .fwd_mem_i  (fwd_mem_i),
        .fwd_wb_i   (fwd_wb_i),
        .result_o   (result_o),
        .stall_o    (stall_o)
    );

endmodule

//--- verification/exe_ref_model.svh
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

// newest hi/lo wins: memory stage, then writeback, then register file
function automatic dword_t pick_hilo(hilo_fwd_t mem, hilo_fwd_t wb, word_t hi_v, word_t lo_v);
    if (mem.whilo) return mem.hilo;
    if (wb.whilo) return wb.hilo;
    return {hi_v, lo_v};
endfunction

function automatic word_t write_data_for(aluop_t op, word_t a, word_t b, word_t ret,
                                         dword_t cur);
    case (op)
        OP_AND, OP_ANDI:   return a & b;
        OP_OR, OP_ORI:     return a | b;
        OP_XOR, OP_XORI:   return a ^ b;
        OP_NOR:            return ~(a | b);
        // upper immediate comes in pre-shifted
        OP_LUI:            return b;
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_LW, OP_SB: return a + b;
        OP_SUB, OP_SUBU:   return a - b;
        OP_SLT, OP_SLTI:   return word_t'($signed(a) < $signed(b));
        OP_SLTU, OP_SLTIU: return word_t'(a < b);
        OP_SLL, OP_SLLV:   return b << a[4:0];
        OP_SRL, OP_SRLV:   return b >> a[4:0];
        OP_SRA, OP_SRAV:   return $signed(b) >>> a[4:0];
        OP_MFHI:           return cur[63:32];
        OP_MFLO:           return cur[31:0];
        OP_JAL:            return ret;
        default:           return '0;
    endcase
endfunction

function automatic dword_t hilo_for(aluop_t op, word_t a, word_t b, dword_t cur);
    longint      sa;
    longint      sb;
    logic [63:0] ua;
    logic [63:0] ub;
    sa = $signed(a);
    sb = $signed(b);
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (op)
        OP_MULT:  return sa * sb;
        OP_MULTU: return ua * ub;
        // truncating division, remainder in hi
        OP_DIV:   return (b == '0) ? '0 : {word_t'(sa % sb), word_t'(sa / sb)};
        OP_DIVU:  return (b == '0) ? '0 : {word_t'(ua % ub), word_t'(ua / ub)};
        OP_MTHI:  return {a, cur[31:0]};
        OP_MTLO:  return {cur[63:32], a};
        default:  return '0;
    endcase
endfunction

// overflow when the exact sum does not fit in 32 signed bits
function automatic logic overflow_for(aluop_t op, word_t a, word_t b);
    longint exact;
    case (op)
        OP_ADD, OP_ADDI: exact = longint'($signed(a)) + longint'($signed(b));
        OP_SUB:          exact = longint'($signed(a)) - longint'($signed(b));
        default:         return 1'b0;
    endcase
    return exact != longint'($signed(exact[31:0]));
endfunction

`endif

//--- verification/exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb
    import exe_op_pkg::*;
    import exe_bus_pkg::*;
();

    logic        cpu_clk_50M;
    logic        reset_i;
    exe_issue_t  issue;
    word_t       hi;
    word_t       lo;
    hilo_fwd_t   fwd_mem;
    hilo_fwd_t   fwd_wb;
    exe_result_t result;
    logic        stall;
    int          errors;
    int          timeouts;
    word_t       rnd;

    aluop_t comb_ops [0:32] = '{
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR, OP_LUI,
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU, OP_LW, OP_SB,
        OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
        OP_MULT, OP_MULTU, OP_JAL, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
    };

    `include "exe_ref_model.svh"

    exe_stage UUT (
        .cpu_clk_50M (cpu_clk_50M),
        .reset_i     (reset_i),
        .issue_i     (issue),
        .hi_i        (hi),
        .lo_i        (lo),
        .fwd_mem_i   (fwd_mem),
        .fwd_wb_i    (fwd_wb),
        .result_o    (result),
        .stall_o     (stall)
    );

    initial cpu_clk_50M = 1'b0;
    always #10 cpu_clk_50M = ~cpu_clk_50M;

    task automatic expect_quiet();
        assert (!stall && !result.wreg && !result.whilo && !result.ovf) else begin
            errors++;
            $display("error at %0t: stall, enables or overflow high around reset", $time);
        end
    endtask

    // called on a falling edge
    task automatic issue_op(aluop_t op, word_t a, word_t b, logic [1:0] fwd_en);
        word_t r;
        r              = $urandom;
        issue.aluop    = op;
        issue.src1     = a;
        issue.src2     = b;
        issue.wa       = r[8:4];
        issue.wreg     = r[0];
        issue.whilo    = r[1];
        issue.ret_addr = $urandom;
        hi             = $urandom;
        lo             = $urandom;
        fwd_mem.whilo  = fwd_en[1];
        fwd_mem.hilo   = {$urandom, $urandom};
        fwd_wb.whilo   = fwd_en[0];
        fwd_wb.hilo    = {$urandom, $urandom};
    endtask

    task automatic check_result();
        dword_t cur;
        word_t  exp_wd;
        dword_t exp_hilo;
        logic   exp_ovf;
        cur      = pick_hilo(fwd_mem, fwd_wb, hi, lo);
        exp_wd   = write_data_for(issue.aluop, issue.src1, issue.src2, issue.ret_addr, cur);
        exp_hilo = hilo_for(issue.aluop, issue.src1, issue.src2, cur);
        exp_ovf  = overflow_for(issue.aluop, issue.src1, issue.src2);
        assert (result.wd === exp_wd) else begin
            errors++;
            $display("error at %0t: op %h src %h %h wd %h, expected %h", $time,
                     issue.aluop, issue.src1, issue.src2, result.wd, exp_wd);
        end
        assert (result.hilo === exp_hilo) else begin
            errors++;
            $display("error at %0t: op %h src %h %h hilo %h, expected %h", $time,
                     issue.aluop, issue.src1, issue.src2, result.hilo, exp_hilo);
        end
        assert (result.ovf === exp_ovf) else begin
            errors++;
            $display("error at %0t: op %h src %h %h overflow %b, expected %b", $time,
                     issue.aluop, issue.src1, issue.src2, result.ovf, exp_ovf);
        end
        assert (result.wa === issue.wa && result.wreg === issue.wreg
                && result.whilo === issue.whilo) else begin
            errors++;
            $display("error at %0t: op %h address or enables not passed through",
                     $time, issue.aluop);
        end
    endtask

    task automatic run_comb(aluop_t op, word_t a, word_t b, logic [1:0] fwd_en);
        issue_op(op, a, b, fwd_en);
        @(negedge cpu_clk_50M);
        assert (stall === 1'b0) else begin
            errors++;
            $display("error at %0t: stall_o high for op %h", $time, op);
        end
        check_result();
    endtask

    task automatic run_div(aluop_t op, word_t a, word_t b);
        int cycles;
        issue_op(op, a, b, 2'b00);
        @(negedge cpu_clk_50M);
        assert (stall === 1'b1) else begin
            errors++;
            $display("error at %0t: stall_o not raised for divide %h / %h", $time, a, b);
        end
        cycles = 1;
        while (stall === 1'b1 && cycles < 40) begin
            @(negedge cpu_clk_50M);
            cycles++;
        end
        if (stall === 1'b1) begin
            timeouts++;
            $display("divide of %h by %h did not finish within 40 cycles", a, b);
        end else begin
            check_result();
        end
    endtask

    initial begin
        void'($urandom(40980));
        errors   = 0;
        timeouts = 0;
        reset_i  = 1'b1;
        issue    = '0;
        hi       = '0;
        lo       = '0;
        fwd_mem  = '0;
        fwd_wb   = '0;
        // overflowing add with enables set, then a divide, all under reset
        issue.aluop = OP_ADD;
        issue.src1  = 32'h7fff_ffff;
        issue.src2  = 32'h0000_0001;
        issue.wreg  = 1'b1;
        issue.whilo = 1'b1;
        repeat (2) @(negedge cpu_clk_50M);
        expect_quiet();
        issue.aluop = OP_DIV;
        issue.src2  = 32'd3;
        repeat (2) @(negedge cpu_clk_50M);
        expect_quiet();
        reset_i = 1'b0;
        issue   = '0;
        @(negedge cpu_clk_50M);
        expect_quiet();

        for (int i = 0; i <= 32; i++) begin
            repeat (8) begin
                rnd = $urandom;
                run_comb(comb_ops[i], $urandom, $urandom, rnd[1:0]);
            end
        end

        // overflow edges
        run_comb(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 2'b00);
        run_comb(OP_ADDI, 32'h7fff_ffff, 32'h0000_0001, 2'b00);
        run_comb(OP_ADD, 32'h8000_0000, 32'h8000_0000, 2'b00);
        run_comb(OP_ADDU, 32'h7fff_ffff, 32'h0000_0001, 2'b00);
        run_comb(OP_SUB, 32'h8000_0000, 32'h0000_0001, 2'b00);
        run_comb(OP_SUB, 32'h0000_0000, 32'h8000_0000, 2'b00);
        run_comb(OP_SUBU, 32'h8000_0000, 32'h0000_0001, 2'b00);
        run_comb(OP_SLT, 32'hffff_ffff, 32'h0000_0001, 2'b00);
        run_comb(OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 2'b00);

        // every forwarding combination for the moves
        for (int en = 0; en < 4; en++) begin
            run_comb(OP_MFHI, $urandom, $urandom, en[1:0]);
            run_comb(OP_MFLO, $urandom, $urandom, en[1:0]);
            run_comb(OP_MTHI, $urandom, $urandom, en[1:0]);
            run_comb(OP_MTLO, $urandom, $urandom, en[1:0]);
        end

        run_div(OP_DIV, 32'hffff_fff9, 32'd2);
        run_div(OP_DIV, 32'd7, 32'hffff_fffe);
        run_div(OP_DIV, 32'hffff_fff9, 32'hffff_fffe);
        run_div(OP_DIVU, 32'hffff_fff9, 32'd2);
        run_div(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_div(OP_DIV, 32'd5, 32'd0);
        run_div(OP_DIVU, 32'd5, 32'd0);
        run_div(OP_DIVU, 32'd3, 32'hffff_ffff);
        // back to back, divisors of mixed size
        repeat (24) begin
            rnd = $urandom;
            run_div(rnd[5] ? OP_DIV : OP_DIVU, $urandom, $urandom >> rnd[4:0]);
        end
        run_comb(OP_ADD, $urandom, $urandom, 2'b00);

        @(negedge cpu_clk_50M);
        $display("failed checks: %0d, divide timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
